// File: icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

`default_nettype none

// cache geometry
`define ICACHE_INDEX_W      6       // 64 sets
`define ICACHE_OFFSET_W     6       // 64-byte line
`define ICACHE_LINE_BITS    512

// burst length code n asks for n+1 beats
`define ICACHE_LEN_LINE     8'd15
`define ICACHE_LEN_UNCACHED 8'd1

// fetch address error
`define ICACHE_EXC_ADEF     7'h08

`default_nettype wire

`endif

// File: icache_addr_pkg.sv
`include "icache_defs.svh"
`default_nettype none

package icache_addr_pkg;

    localparam int TAG_W   = 32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W;
    localparam int CHUNK_W = `ICACHE_OFFSET_W - 3;   // 8-byte chunks in a line

    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0]   index_t;
    typedef logic [CHUNK_W-1:0]           chunk_sel_t;
    typedef logic [`ICACHE_LINE_BITS-1:0] line_t;
    typedef logic                         way_t;

    // fetch or one of the two invalidates
    typedef enum logic [1:0] {
        OP_FETCH   = 2'd0,
        OP_IDX_INV = 2'd1,   // way from vaddr[0]
        OP_HIT_INV = 2'd2
    } cacop_e;

endpackage

`default_nettype wire

// File: icache_bus_pkg.sv
`default_nettype none

package icache_bus_pkg;

    // fetch stage to cache
    typedef struct packed {
        logic [31:0]            vaddr;
        logic [31:0]            paddr;
        logic                   uncache;
        icache_addr_pkg::cacop_e op;
    } fetch_req_t;

    // cache to fetch stage, one per accepted request
    typedef struct packed {
        logic [63:0] data;   // two instructions
        logic [31:0] pc;
        logic [6:0]  exc;    // zero when no error
        logic        done;   // cache op finished
    } fetch_rsp_t;

    // read request to memory
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } mem_req_t;

endpackage

`default_nettype wire

// File: icache_way_ram.sv
`include "icache_defs.svh"
`default_nettype none

module icache_way_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  wire logic                       clk,
    input  wire logic [`ICACHE_INDEX_W-1:0] i_raddr,
    output entry_t                          o_rdata,
    input  wire logic                       i_we,
    input  wire logic [`ICACHE_INDEX_W-1:0] i_waddr,
    input  wire entry_t                     i_wdata
);

    localparam int DEPTH = 1 << `ICACHE_INDEX_W;

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read returns the old entry on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

// File: icache_req_buf.sv
`include "icache_defs.svh"
`default_nettype none

module icache_req_buf (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_load,
    input  wire icache_bus_pkg::fetch_req_t i_req,
    output icache_addr_pkg::index_t         o_index,
    output icache_addr_pkg::tag_t           o_tag,
    output icache_addr_pkg::chunk_sel_t     o_chunk,
    output logic                            o_uncache,
    output icache_addr_pkg::cacop_e         o_op,
    output logic [31:0]                     o_pc,
    output logic                            o_misaligned,
    output icache_bus_pkg::mem_req_t        o_mem_req
);

    import icache_addr_pkg::*;
    import icache_bus_pkg::*;

    logic        uncache_q;
    cacop_e      op_q;
    logic [31:0] vaddr_q;
    logic [31:0] paddr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            uncache_q <= 1'b0;
            op_q      <= OP_FETCH;
        end else if (i_load) begin
            uncache_q <= i_req.uncache;
            op_q      <= i_req.op;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            vaddr_q <= i_req.vaddr;
            paddr_q <= i_req.paddr;
        end
    end

    assign o_index   = vaddr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];   // virtually indexed
    assign o_tag     = paddr_q[31 -: TAG_W];                           // physically tagged
    // uncached data lands in the top 64 bits of the returned line
    assign o_chunk   = uncache_q ? '1 : vaddr_q[`ICACHE_OFFSET_W-1:3];
    assign o_uncache = uncache_q;
    assign o_op      = op_q;
    assign o_pc      = vaddr_q;

    assign o_misaligned = (op_q == OP_FETCH) && (vaddr_q[1:0] != 2'b00);

    assign o_mem_req = mem_req_t'{
        addr: uncache_q ? {paddr_q[31:3], 3'b000}
                        : {paddr_q[31 -: TAG_W], o_index, {`ICACHE_OFFSET_W{1'b0}}},
        len:  uncache_q ? `ICACHE_LEN_UNCACHED : `ICACHE_LEN_LINE
    };

endmodule

`default_nettype wire

// File: icache_lookup.sv
`default_nettype none

module icache_lookup (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire icache_addr_pkg::tag_t      i_tag,
    input  wire icache_addr_pkg::index_t    i_index,
    input  wire icache_addr_pkg::tag_t      i_tag_rd0,
    input  wire icache_addr_pkg::tag_t      i_tag_rd1,
    input  wire icache_addr_pkg::line_t     i_line_rd0,
    input  wire icache_addr_pkg::line_t     i_line_rd1,
    input  wire logic [1:0]                 i_set_valid,
    input  wire logic [1:0]                 i_clear_valid,
    input  wire icache_addr_pkg::line_t     i_refill_line,
    input  wire logic                       i_from_refill,
    input  wire icache_addr_pkg::chunk_sel_t i_chunk,
    output logic [1:0]                      o_hit,
    output logic [63:0]                     o_data
);

    import icache_addr_pkg::*;

    localparam int SETS = 1 << $bits(index_t);

    logic [SETS-1:0] valid_q [2];
    line_t           refill_q;   // line from the handshake cycle
    line_t           sel_line;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (i_set_valid[w]) begin
                    valid_q[w][i_index] <= 1'b1;
                end else if (i_clear_valid[w]) begin
                    valid_q[w][i_index] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        refill_q <= i_refill_line;
    end

    assign o_hit[0] = valid_q[0][i_index] && (i_tag_rd0 == i_tag);
    assign o_hit[1] = valid_q[1][i_index] && (i_tag_rd1 == i_tag);

    always_comb begin
        if (i_from_refill) begin
            sel_line = refill_q;
        end else if (o_hit[1]) begin
            sel_line = i_line_rd1;
        end else begin
            sel_line = i_line_rd0;   // way 0 or don't care
        end
    end

    assign o_data = sel_line[{i_chunk, 6'd0} +: 64];

endmodule

`default_nettype wire

// File: icache_lru.sv
`default_nettype none

module icache_lru (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire icache_addr_pkg::index_t i_index,
    input  wire logic                    i_touch,
    input  wire icache_addr_pkg::way_t   i_way,
    output icache_addr_pkg::way_t        o_victim
);

    import icache_addr_pkg::*;

    localparam int SETS = 1 << $bits(index_t);

    logic [SETS-1:0] mru_q;   // last way used per set

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru_q <= '0;
        end else if (i_touch) begin
            mru_q[i_index] <= i_way;
        end
    end

    // two ways, so the victim is simply the other one
    assign o_victim = way_t'(~mru_q[i_index]);

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`include "icache_defs.svh"
`default_nettype none

module icache_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    i_req_valid,
    output logic                         o_req_ready,
    output logic                         o_load,
    input  wire icache_addr_pkg::cacop_e i_op,
    input  wire logic                    i_uncache,
    input  wire logic                    i_misaligned,
    input  wire logic [1:0]              i_hit,
    input  wire icache_addr_pkg::way_t   i_victim,
    input  wire logic                    i_mem_ready,
    output logic                         o_mem_valid,
    output logic [1:0]                   o_data_we,
    output logic [1:0]                   o_set_valid,
    output logic [1:0]                   o_clear_valid,
    output logic                         o_from_refill,
    output logic                         o_touch,
    output icache_addr_pkg::way_t        o_touch_way,
    output logic                         o_rsp_valid,
    output logic [6:0]                   o_rsp_exc,
    output logic                         o_rsp_done
);

    import icache_addr_pkg::*;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4
    } state_e;

    state_e     state_q;
    state_e     state_d;
    logic [1:0] victim_oh;
    logic [1:0] fill_we;
    logic       cached_hit;

    assign victim_oh  = i_victim ? 2'b10 : 2'b01;
    assign fill_we    = i_uncache ? 2'b00 : victim_oh;   // uncached fills nothing
    assign cached_hit = (i_op == OP_FETCH) && !i_uncache && (i_hit != 2'b00);
    assign o_load     = i_req_valid && o_req_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        o_req_ready   = 1'b0;
        o_mem_valid   = 1'b0;
        o_data_we     = 2'b00;
        o_set_valid   = 2'b00;
        o_clear_valid = 2'b00;
        o_from_refill = 1'b0;
        o_touch       = 1'b0;
        o_touch_way   = way_t'(i_hit[1]);
        o_rsp_valid   = 1'b0;
        o_rsp_exc     = 7'd0;
        o_rsp_done    = 1'b0;

        case (state_q)
            IDLE: begin
                o_req_ready = 1'b1;
                if (i_req_valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (i_misaligned) begin
                    o_rsp_valid = 1'b1;
                    o_rsp_exc   = `ICACHE_EXC_ADEF;
                    o_req_ready = 1'b1;
                    state_d     = i_req_valid ? LOOKUP : IDLE;
                end else if (i_op != OP_FETCH) begin
                    state_d = CACOP;   // tags for the op are read next cycle
                end else if (cached_hit) begin
                    o_rsp_valid = 1'b1;
                    o_req_ready = 1'b1;   // pipelined hits
                    o_touch     = 1'b1;
                    state_d     = i_req_valid ? LOOKUP : IDLE;
                end else begin
                    o_mem_valid = 1'b1;
                    if (i_mem_ready) begin
                        o_data_we = fill_we;   // line is only valid this cycle
                        state_d   = REFILL;
                    end else begin
                        state_d = MISS;
                    end
                end
            end
            MISS: begin
                o_mem_valid = 1'b1;
                if (i_mem_ready) begin
                    o_data_we = fill_we;
                    state_d   = REFILL;
                end
            end
            REFILL: begin
                o_from_refill = 1'b1;
                o_rsp_valid   = 1'b1;
                o_req_ready   = 1'b1;
                if (!i_uncache) begin
                    o_set_valid = victim_oh;
                    o_touch     = 1'b1;
                    o_touch_way = i_victim;
                end
                state_d = i_req_valid ? LOOKUP : IDLE;
            end
            CACOP: begin
                // i_hit carries the addressed way for index-invalidate
                o_clear_valid = i_hit;
                o_rsp_valid   = 1'b1;
                o_rsp_done    = 1'b1;
                state_d       = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: icache.sv
`include "icache_defs.svh"
`default_nettype none

module icache (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_req_valid,
    output logic                            o_req_ready,
    input  wire icache_bus_pkg::fetch_req_t i_req,
    output logic                            o_rsp_valid,
    output icache_bus_pkg::fetch_rsp_t      o_rsp,
    output logic                            o_mem_valid,
    input  wire logic                       i_mem_ready,
    output icache_bus_pkg::mem_req_t        o_mem_req,
    input  wire icache_addr_pkg::line_t     i_mem_data
);

    import icache_addr_pkg::*;

    logic        load;
    index_t      buf_index;
    index_t      rd_index;
    tag_t        buf_tag;
    chunk_sel_t  buf_chunk;
    logic        buf_uncache;
    cacop_e      buf_op;
    logic [31:0] buf_pc;
    logic        buf_misaligned;
    tag_t        tag_rd [2];
    line_t       line_rd [2];
    logic [1:0]  hit;
    logic [1:0]  ctrl_hit;
    logic [1:0]  data_we;
    logic [1:0]  set_valid;
    logic [1:0]  clear_valid;
    logic        from_refill;
    logic        touch;
    way_t        touch_way;
    way_t        victim;
    logic [63:0] rsp_data;
    logic [6:0]  rsp_exc;
    logic        rsp_done;

    // new index on accept, else keep the buffered set on the RAM outputs
    assign rd_index = load ? i_req.vaddr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W] : buf_index;
    assign ctrl_hit = (buf_op == OP_IDX_INV) ? (buf_pc[0] ? 2'b10 : 2'b01) : hit;
    assign o_rsp    = '{data: rsp_data, pc: buf_pc, exc: rsp_exc, done: rsp_done};

    icache_req_buf u_req_buf (
        .clk(clk), .rstn(rstn), .i_load(load), .i_req(i_req),
        .o_index(buf_index), .o_tag(buf_tag), .o_chunk(buf_chunk),
        .o_uncache(buf_uncache), .o_op(buf_op), .o_pc(buf_pc),
        .o_misaligned(buf_misaligned), .o_mem_req(o_mem_req)
    );

    icache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
        .o_load(load), .i_op(buf_op), .i_uncache(buf_uncache),
        .i_misaligned(buf_misaligned), .i_hit(ctrl_hit), .i_victim(victim),
        .i_mem_ready(i_mem_ready), .o_mem_valid(o_mem_valid), .o_data_we(data_we),
        .o_set_valid(set_valid), .o_clear_valid(clear_valid),
        .o_from_refill(from_refill), .o_touch(touch), .o_touch_way(touch_way),
        .o_rsp_valid(o_rsp_valid), .o_rsp_exc(rsp_exc), .o_rsp_done(rsp_done)
    );

    icache_lookup u_lookup (
        .clk(clk), .rstn(rstn), .i_tag(buf_tag), .i_index(buf_index),
        .i_tag_rd0(tag_rd[0]), .i_tag_rd1(tag_rd[1]),
        .i_line_rd0(line_rd[0]), .i_line_rd1(line_rd[1]),
        .i_set_valid(set_valid), .i_clear_valid(clear_valid),
        .i_refill_line(i_mem_data), .i_from_refill(from_refill),
        .i_chunk(buf_chunk), .o_hit(hit), .o_data(rsp_data)
    );

    icache_lru u_lru (
        .clk(clk), .rstn(rstn), .i_index(buf_index), .i_touch(touch),
        .i_way(touch_way), .o_victim(victim)
    );

    for (genvar w = 0; w < 2; w++) begin : g_way
        icache_way_ram #(.entry_t(line_t)) u_data (
            .clk(clk), .i_raddr(rd_index), .o_rdata(line_rd[w]),
            .i_we(data_we[w]), .i_waddr(buf_index), .i_wdata(i_mem_data)
        );
        icache_way_ram #(.entry_t(tag_t)) u_tag (
            .clk(clk), .i_raddr(rd_index), .o_rdata(tag_rd[w]),
            .i_we(data_we[w]), .i_waddr(buf_index), .i_wdata(buf_tag)
        );
    end

endmodule

`default_nettype wire

// File: tb_icache_mem.sv
`include "icache_defs.svh"
`default_nettype none

module tb_icache_mem (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     i_valid,
    input  wire icache_bus_pkg::mem_req_t i_req,
    output logic                          o_ready,
    output icache_addr_pkg::line_t        o_data,
    output int                            o_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import icache_addr_pkg::*;
    import icache_bus_pkg::*;

    int delay;

    // burst of len+1 words, packed into the top of the line
    function automatic line_t build_line(input mem_req_t r);
        line_t l;
        int    first;
        l     = '0;
        first = 15 - int'(r.len);
        for (int k = 0; k <= int'(r.len); k++) begin
            l[(first + k) * 32 +: 32] = ~(r.addr + 32'(4 * k));   // inverted address
        end
        return l;
    endfunction

    initial begin
        o_ready = 1'b0;
        o_data  = '0;
        o_count = 0;
        forever begin
            @(posedge clk);
            #1;
            o_ready = 1'b0;
            if (rstn && i_valid) begin
                delay = $urandom_range(0, 5);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                o_ready = 1'b1;   // handshake at the next edge
                o_data  = build_line(i_req);
                o_count = o_count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_icache.sv
`include "icache_defs.svh"
`default_nettype none

module tb_icache;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_addr_pkg::*;
    import icache_bus_pkg::*;

    localparam int K_HIT  = 0;
    localparam int K_MISS = 1;   // may or may not go to memory
    localparam int K_ERR  = 2;
    localparam int K_OP   = 3;
    localparam int N_RANDOM = 60;
    localparam int WATCHDOG_CYCLES = (30 + N_RANDOM) * 200;

    typedef struct packed {
        logic [63:0] data;
        logic [31:0] pc;
        logic [6:0]  exc;
        logic        done;
        logic        chk_data;
        logic [1:0]  lat;        // zero means not fixed
        logic        may_mem;
        logic [31:0] maddr;
        logic [7:0]  mlen;
        logic [31:0] acc;        // acceptance cycle
    } exp_t;

    logic       clk;
    logic       rstn;
    logic       i_req_valid;
    logic       o_req_ready;
    fetch_req_t i_req;
    logic       o_rsp_valid;
    fetch_rsp_t o_rsp;
    logic       o_mem_valid;
    logic       i_mem_ready;
    mem_req_t   o_mem_req;
    line_t      i_mem_data;
    int         mem_count;

    exp_t  exp_arr [512];
    exp_t  head;
    int    rd_ptr;
    int    wr_ptr;
    int    cyc;
    int    errors;
    logic  pending;
    string cur_test;

    icache u_icache (
        .clk(clk), .rstn(rstn), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
        .i_req(i_req), .o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp),
        .o_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready), .o_mem_req(o_mem_req),
        .i_mem_data(i_mem_data)
    );

    tb_icache_mem u_mem (
        .clk(clk), .rstn(rstn), .i_valid(o_mem_valid), .i_req(o_mem_req),
        .o_ready(i_mem_ready), .o_data(i_mem_data), .o_count(mem_count)
    );

    always #4 clk = ~clk;

    assign head    = exp_arr[rd_ptr];
    assign pending = (rd_ptr != wr_ptr);

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rstn && o_rsp_valid) begin
            rd_ptr <= rd_ptr + 1;   // responses come in acceptance order
        end
    end

    a_rsp_pending: assert property (@(posedge clk) disable iff (!rstn)
        o_rsp_valid |-> pending)
        else begin
            errors = errors + 1;
            $display("%s: response arrived with no request pending", cur_test);
        end

    a_rsp_data: assert property (@(posedge clk) disable iff (!rstn)
        (o_rsp_valid && pending && head.chk_data) |-> (o_rsp.data == head.data))
        else begin
            errors = errors + 1;
            $display("MISMATCH %s data expected %h actual %h", cur_test,
                     $sampled(head.data), $sampled(o_rsp.data));
        end

    a_rsp_pc: assert property (@(posedge clk) disable iff (!rstn)
        (o_rsp_valid && pending) |-> (o_rsp.pc == head.pc))
        else begin
            errors = errors + 1;
            $display("MISMATCH %s pc expected %h actual %h", cur_test,
                     $sampled(head.pc), $sampled(o_rsp.pc));
        end

    a_rsp_flags: assert property (@(posedge clk) disable iff (!rstn)
        (o_rsp_valid && pending) |-> (o_rsp.exc == head.exc && o_rsp.done == head.done))
        else begin
            errors = errors + 1;
            $display("MISMATCH %s exc/done expected %h/%b actual %h/%b", cur_test,
                     $sampled(head.exc), $sampled(head.done),
                     $sampled(o_rsp.exc), $sampled(o_rsp.done));
        end

    a_rsp_latency: assert property (@(posedge clk) disable iff (!rstn)
        (o_rsp_valid && pending && head.lat != 0) |-> ((cyc - int'(head.acc)) == head.lat))
        else begin
            errors = errors + 1;
            $display("MISMATCH %s latency expected %0d actual %0d", cur_test,
                     $sampled(head.lat), $sampled(cyc) - int'($sampled(head.acc)));
        end

    // memory request only for a possible miss and with the right address and length
    a_mem_req: assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_valid && i_mem_ready) |->
            (pending && head.may_mem && o_mem_req == {head.maddr, head.mlen}))
        else begin
            errors = errors + 1;
            $display("MISMATCH %s memory request expected %h/%h actual %h/%h", cur_test,
                     $sampled(head.maddr), $sampled(head.mlen),
                     $sampled(o_mem_req.addr), $sampled(o_mem_req.len));
        end

    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_valid && !i_mem_ready) |=> (o_mem_valid && $stable(o_mem_req)))
        else begin
            errors = errors + 1;
            $display("%s: memory request dropped or changed before ready", cur_test);
        end

    // hits and address errors keep the fetch side open
    a_hit_ready: assert property (@(posedge clk) disable iff (!rstn)
        (o_rsp_valid && pending && head.lat == 2'd1) |-> o_req_ready)
        else begin
            errors = errors + 1;
            $display("%s: cache not ready during a one-cycle response", cur_test);
        end

    a_refill_rsp: assert property (@(posedge clk) disable iff (!rstn)
        (o_mem_valid && i_mem_ready) |=> o_rsp_valid)
        else begin
            errors = errors + 1;
            $display("%s: no response in the cycle after the memory handshake", cur_test);
        end

    task automatic issue(input logic [31:0] va, input logic unc, input cacop_e op,
                         input int kind);
        exp_t        e;
        logic [31:0] a;
        logic        accepted;
        a          = {va[31:3], 3'b000};   // paddr equals vaddr here
        e          = '0;
        e.data     = {~(a + 32'd4), ~a};
        e.pc       = va;
        e.exc      = (kind == K_ERR) ? `ICACHE_EXC_ADEF : 7'd0;
        e.done     = (kind == K_OP);
        e.chk_data = (kind == K_HIT) || (kind == K_MISS);
        e.lat      = (kind == K_OP) ? 2'd2 : (kind == K_MISS) ? 2'd0 : 2'd1;
        e.may_mem  = (kind == K_MISS);
        e.maddr    = unc ? a : {va[31:6], 6'b0};
        e.mlen     = unc ? `ICACHE_LEN_UNCACHED : `ICACHE_LEN_LINE;
        i_req_valid = 1'b1;
        i_req       = '{vaddr: va, paddr: va, uncache: unc, op: op};
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (o_req_ready) begin
                e.acc           = 32'(cyc);
                exp_arr[wr_ptr] = e;
                wr_ptr          = wr_ptr + 1;
                accepted        = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        i_req_valid = 1'b0;
    endtask

    task automatic drain();
        while (rd_ptr != wr_ptr) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_mem_count(input int expected);
        assert (mem_count == expected)
        else begin
            errors = errors + 1;
            $display("MISMATCH %s memory requests expected %0d actual %0d", cur_test,
                     expected, mem_count);
        end
    endtask

    task automatic random_traffic();
        logic [19:0] pool [4];
        logic [31:0] va;
        int          r;
        int          gap;
        pool = '{20'h12345, 20'h0abcd, 20'h77777, 20'h00400};
        for (int i = 0; i < N_RANDOM; i++) begin
            va = {pool[$urandom_range(0, 3)], 6'($urandom_range(0, 63)),
                  3'($urandom_range(0, 7)), 3'b000};
            r  = $urandom_range(0, 9);
            if (r == 0) begin
                va[1:0] = 2'($urandom_range(1, 3));
                issue(va, 1'b0, OP_FETCH, K_ERR);
            end else begin
                issue(va, r == 1, OP_FETCH, K_MISS);   // hit or miss and the data must match
            end
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        drain();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: responses stopped arriving");
        $display("tests failed");
        $finish;
    end

    initial begin
        int c0;
        void'($urandom(32'hfd46));
        clk         = 1'b0;
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        rd_ptr      = 0;
        wr_ptr      = 0;
        cyc         = 0;
        errors      = 0;
        cur_test    = "reset";
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;

        cur_test = "miss_then_hit";
        c0 = mem_count;
        issue(32'h0001_0040, 1'b0, OP_FETCH, K_MISS);
        issue(32'h0001_0058, 1'b0, OP_FETCH, K_HIT);
        issue(32'h0001_0048, 1'b0, OP_FETCH, K_HIT);   // back-to-back hits
        issue(32'h0001_0070, 1'b0, OP_FETCH, K_HIT);
        drain();
        check_mem_count(c0 + 1);

        cur_test = "replacement";   // set 2 with tags A B C
        c0 = mem_count;
        issue(32'h0002_0080, 1'b0, OP_FETCH, K_MISS);
        issue(32'h0003_0088, 1'b0, OP_FETCH, K_MISS);
        issue(32'h0002_0090, 1'b0, OP_FETCH, K_HIT);
        issue(32'h0004_0098, 1'b0, OP_FETCH, K_MISS);   // evicts B
        issue(32'h0002_00a0, 1'b0, OP_FETCH, K_HIT);
        issue(32'h0003_0080, 1'b0, OP_FETCH, K_MISS);
        drain();
        check_mem_count(c0 + 4);

        cur_test = "uncached";
        c0 = mem_count;
        issue(32'h0005_00cc, 1'b1, OP_FETCH, K_MISS);
        issue(32'h0005_00cc, 1'b1, OP_FETCH, K_MISS);
        drain();
        check_mem_count(c0 + 2);

        cur_test = "misaligned";
        c0 = mem_count;
        issue(32'h0006_0102, 1'b0, OP_FETCH, K_ERR);
        drain();
        check_mem_count(c0);

        cur_test = "index_invalidate";   // fresh set where the first fill lands in way 1
        c0 = mem_count;
        issue(32'h0007_0140, 1'b0, OP_FETCH, K_MISS);
        issue(32'h0007_0148, 1'b0, OP_FETCH, K_HIT);
        issue(32'h0007_0141, 1'b0, OP_IDX_INV, K_OP);
        issue(32'h0007_0140, 1'b0, OP_FETCH, K_MISS);
        drain();
        check_mem_count(c0 + 2);

        cur_test = "hit_invalidate";
        c0 = mem_count;
        issue(32'h0008_0180, 1'b0, OP_FETCH, K_MISS);
        issue(32'h0008_0180, 1'b0, OP_HIT_INV, K_OP);
        issue(32'h0008_0188, 1'b0, OP_FETCH, K_MISS);
        drain();
        check_mem_count(c0 + 2);

        cur_test = "hit_invalidate_uncached";
        c0 = mem_count;
        issue(32'h0009_01c0, 1'b0, OP_FETCH, K_MISS);
        issue(32'h000a_01c0, 1'b1, OP_HIT_INV, K_OP);   // no such line so nothing changes
        issue(32'h0009_01c8, 1'b0, OP_FETCH, K_HIT);
        drain();
        check_mem_count(c0 + 1);

        cur_test = "random";
        random_traffic();

        $display("requests %0d responses %0d memory requests %0d errors %0d",
                 wr_ptr, rd_ptr, mem_count, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
icache_addr_pkg.sv
icache_bus_pkg.sv
icache_way_ram.sv
icache_req_buf.sv
icache_lookup.sv
icache_lru.sv
icache_ctrl.sv
icache.sv
tb_icache_mem.sv
tb_icache.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -f src.f -o sim_icache

./obj_dir/sim_icache | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"
